//--- logic/cordic_nco_pkg.sv
/* CORDIC NCO shared definitions
   Formats, fold and wrap constants, arctangent table and sample type */

package cordic_nco_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Angle and sample word width
  localparam int data_width = 16;
  // Fraction bits of Q2.13 radians and amplitudes
  localparam int frac_bits = 13;
  // Fold register plus one register per iteration
  localparam int num_stages = 14;
  // Sample buffer entries, power of two
  localparam int fifo_depth = 16;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  // Occupancy must also hold the full value
  localparam int fifo_count_width = $clog2(fifo_depth + 1);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Signed radians, Q2.13
  typedef logic signed [data_width-1:0] angle_t;
  // One guard bit above angle_t for sums and the larger constants
  typedef logic signed [data_width:0] wide_angle_t;

  // Fold applied by the first core stage
  typedef enum logic [1:0] {
    quad_1,
    quad_2,
    quad_3,
    quad_4
  } quadrant_e;

  // One generator output word
  typedef struct packed {
    logic signed [data_width-1:0] sine;
    logic signed [data_width-1:0] cosine;
  } sample_t;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  // Weight of one unit
  localparam real unit = 2.0 ** frac_bits;
  localparam real real_pi = 3.14159265358979;

  localparam angle_t pi_half = angle_t'(int'(real_pi / 2.0 * unit));
  localparam angle_t pi = angle_t'(int'(real_pi * unit));
  // These two exceed the Q2.13 range and carry the guard bit
  localparam wide_angle_t three_pi_half = wide_angle_t'(int'(real_pi * 1.5 * unit));
  localparam wide_angle_t two_pi = wide_angle_t'(int'(real_pi * 2.0 * unit));

  // Inverse CORDIC gain with 3 percent headroom
  localparam angle_t cordic_amplitude = angle_t'(int'(0.607253 * 0.97 * unit));

  // atan(2^-i) for i = 0 .. 12
  localparam angle_t atan_table [0:num_stages-2] = '{
    16'sd6434, 16'sd3798, 16'sd2007, 16'sd1019, 16'sd511,
    16'sd256, 16'sd128, 16'sd64, 16'sd32, 16'sd16,
    16'sd8, 16'sd4, 16'sd2
  };

endpackage

//--- logic/phase_accumulator.sv
/* Phase accumulator for the NCO
   Steps a radian angle by a loaded increment and wraps it into -pi .. pi */

module phase_accumulator (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load,
  input  logic                   run,
  input  cordic_nco_pkg::angle_t start_angle,
  input  cordic_nco_pkg::angle_t step,
  output cordic_nco_pkg::angle_t angle,
  output logic                   angle_valid
);

  // Angle emitted in the next running cycle
  cordic_nco_pkg::angle_t      next_angle;
  // Increment captured at load
  cordic_nco_pkg::angle_t      step_reg;
  // Unwrapped sum, guard bit keeps it exact
  cordic_nco_pkg::wide_angle_t sum;
  cordic_nco_pkg::angle_t      wrapped;

  ////////////////////////////////////////
  // Wrap rule
  ////////////////////////////////////////

  always_comb begin : wrap_logic
    sum = cordic_nco_pkg::wide_angle_t'(next_angle) + cordic_nco_pkg::wide_angle_t'(step_reg);
    if (sum > cordic_nco_pkg::wide_angle_t'(cordic_nco_pkg::pi)) begin
      // Above pi, go around once backwards
      wrapped = cordic_nco_pkg::angle_t'(sum - cordic_nco_pkg::two_pi);
    end else if (sum < -cordic_nco_pkg::wide_angle_t'(cordic_nco_pkg::pi)) begin
      // Below minus pi, go around once forwards
      wrapped = cordic_nco_pkg::angle_t'(sum + cordic_nco_pkg::two_pi);
    end else begin
      wrapped = cordic_nco_pkg::angle_t'(sum);
    end
  end

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin : accum_regs
    if (!rst_n) begin
      next_angle <= '0;
      step_reg   <= '0;
    end else if (load) begin
      // Load takes priority over run
      next_angle <= start_angle;
      step_reg   <= step;
    end else if (run) begin
      next_angle <= wrapped;
    end
  end

  // Current angle goes out while running
  assign angle = next_angle;
  // No sample in a load cycle
  assign angle_valid = run & ~load;

endmodule

//--- logic/cordic_rotation_core.sv
/* Pipelined CORDIC rotation core
   Folds each angle into the right half-plane and iterates to sine and cosine */

module cordic_rotation_core (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cordic_nco_pkg::angle_t  angle,
  input  logic                    angle_valid,
  output cordic_nco_pkg::sample_t result,
  output logic                    result_valid
);

  // Magnitude of the input angle, wide so the most negative code survives
  cordic_nco_pkg::wide_angle_t abs_angle;
  cordic_nco_pkg::quadrant_e   quadrant;

  // Per stage vector, x is cosine and y is sine
  logic signed [cordic_nco_pkg::data_width-1:0] x_pipe [cordic_nco_pkg::num_stages];
  logic signed [cordic_nco_pkg::data_width-1:0] y_pipe [cordic_nco_pkg::num_stages];
  // Residual angle still to rotate
  cordic_nco_pkg::angle_t                       z_pipe [cordic_nco_pkg::num_stages];

  // Sample valid and input sign travel alongside the vectors
  logic [cordic_nco_pkg::num_stages-1:0] valid_pipe;
  logic [cordic_nco_pkg::num_stages-1:0] neg_pipe;

  ////////////////////////////////////////
  // Stage 0 fold
  ////////////////////////////////////////

  // Only the magnitude is rotated, sine sign restored at the output
  assign abs_angle = angle[cordic_nco_pkg::data_width-1] ?
                     -cordic_nco_pkg::wide_angle_t'(angle) :
                      cordic_nco_pkg::wide_angle_t'(angle);

  always_comb begin : classify
    if (abs_angle <= cordic_nco_pkg::pi_half) begin
      quadrant = cordic_nco_pkg::quad_1;
    end else if (abs_angle <= cordic_nco_pkg::pi) begin
      quadrant = cordic_nco_pkg::quad_2;
    end else if (abs_angle <= cordic_nco_pkg::three_pi_half) begin
      quadrant = cordic_nco_pkg::quad_3;
    end else begin
      quadrant = cordic_nco_pkg::quad_4;
    end
  end

  always_ff @(posedge clk) begin : fold_stage
    case (quadrant)
      cordic_nco_pkg::quad_1: begin
        // Already within reach of the iterations
        x_pipe[0] <= cordic_nco_pkg::cordic_amplitude;
        y_pipe[0] <= '0;
        z_pipe[0] <= cordic_nco_pkg::angle_t'(abs_angle);
      end
      cordic_nco_pkg::quad_2: begin
        // Pre-rotate by pi/2
        x_pipe[0] <= '0;
        y_pipe[0] <= cordic_nco_pkg::cordic_amplitude;
        z_pipe[0] <= cordic_nco_pkg::angle_t'(abs_angle - cordic_nco_pkg::pi_half);
      end
      cordic_nco_pkg::quad_3: begin
        // Pre-rotate by 3pi/2, residual ends up negative
        x_pipe[0] <= '0;
        y_pipe[0] <= -cordic_nco_pkg::cordic_amplitude;
        z_pipe[0] <= cordic_nco_pkg::angle_t'(abs_angle - cordic_nco_pkg::three_pi_half);
      end
      default: begin
        // Full turn back, start vector unchanged
        x_pipe[0] <= cordic_nco_pkg::cordic_amplitude;
        y_pipe[0] <= '0;
        z_pipe[0] <= cordic_nco_pkg::angle_t'(abs_angle - cordic_nco_pkg::two_pi);
      end
    endcase
  end

  ////////////////////////////////////////
  // Iterations
  ////////////////////////////////////////

  for (genvar k = 1; k < cordic_nco_pkg::num_stages; k++) begin : iter_stage
    logic signed [cordic_nco_pkg::data_width-1:0] x_shr;
    logic signed [cordic_nco_pkg::data_width-1:0] y_shr;
    logic                                         z_neg;

    // Arithmetic shift by the iteration index
    assign x_shr = x_pipe[k-1] >>> (k - 1);
    assign y_shr = y_pipe[k-1] >>> (k - 1);
    // Rotate clockwise while the residual is negative
    assign z_neg = z_pipe[k-1][cordic_nco_pkg::data_width-1];

    always_ff @(posedge clk) begin : micro_rotation
      if (z_neg) begin
        x_pipe[k] <= x_pipe[k-1] + y_shr;
        y_pipe[k] <= y_pipe[k-1] - x_shr;
        z_pipe[k] <= z_pipe[k-1] + cordic_nco_pkg::atan_table[k-1];
      end else begin
        x_pipe[k] <= x_pipe[k-1] - y_shr;
        y_pipe[k] <= y_pipe[k-1] + x_shr;
        z_pipe[k] <= z_pipe[k-1] - cordic_nco_pkg::atan_table[k-1];
      end
    end
  end

  ////////////////////////////////////////
  // Side channels and output
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin : valid_chain
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[cordic_nco_pkg::num_stages-2:0], angle_valid};
    end
  end

  always_ff @(posedge clk) begin : sign_chain
    neg_pipe <= {neg_pipe[cordic_nco_pkg::num_stages-2:0],
                 angle[cordic_nco_pkg::data_width-1]};
  end

  // sin(-a) = -sin(a), cosine is even
  assign result.sine = neg_pipe[cordic_nco_pkg::num_stages-1] ?
                       -y_pipe[cordic_nco_pkg::num_stages-1] :
                        y_pipe[cordic_nco_pkg::num_stages-1];
  assign result.cosine = x_pipe[cordic_nco_pkg::num_stages-1];
  assign result_valid  = valid_pipe[cordic_nco_pkg::num_stages-1];

endmodule

//--- logic/sample_fifo.sv
/* Show-ahead sample FIFO
   Drops writes when full and keeps a sticky overflow flag until cleared */

module sample_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clear,
  input  logic                    push,
  input  cordic_nco_pkg::sample_t data_in,
  input  logic                    pop,
  output cordic_nco_pkg::sample_t head,
  output logic                    empty,
  output logic                    overflow
);

  // Ring storage
  cordic_nco_pkg::sample_t mem [cordic_nco_pkg::fifo_depth];

  logic [cordic_nco_pkg::fifo_ptr_width-1:0]   wr_ptr;
  logic [cordic_nco_pkg::fifo_ptr_width-1:0]   rd_ptr;
  logic [cordic_nco_pkg::fifo_count_width-1:0] count;
  logic                                        full;
  logic                                        do_push;
  logic                                        do_pop;

  assign full  = (count == cordic_nco_pkg::fifo_count_width'(cordic_nco_pkg::fifo_depth));
  assign empty = (count == '0);

  // Pop on empty is ignored
  assign do_pop = pop & ~empty;
  // A pop in the same cycle frees the slot for the push
  assign do_push = push & (~full | do_pop);

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin : store
    if (do_push) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin : pointers
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap naturally at the power-of-two depth
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sticky until the next load
  always_ff @(posedge clk or negedge rst_n) begin : overflow_flag
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (clear) begin
      overflow <= 1'b0;
    end else if (push && !do_push) begin
      overflow <= 1'b1;
    end
  end

  // Oldest entry always visible
  assign head = mem[rd_ptr];

endmodule

//--- logic/cordic_nco_top.sv
/* CORDIC sine and cosine NCO
   Phase accumulator feeds the rotation core, results queue in a sample FIFO */

module cordic_nco_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load,
  input  logic                    run,
  input  cordic_nco_pkg::angle_t  start_angle,
  input  cordic_nco_pkg::angle_t  step,
  input  logic                    pop,
  output cordic_nco_pkg::sample_t head,
  output logic                    empty,
  output logic                    overflow
);

  // Producer to core
  cordic_nco_pkg::angle_t  angle;
  logic                    angle_valid;
  // Core to buffer
  cordic_nco_pkg::sample_t result;
  logic                    result_valid;

  phase_accumulator phase_accumulator_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .load        (load),
    .run         (run),
    .start_angle (start_angle),
    .step        (step),
    .angle       (angle),
    .angle_valid (angle_valid)
  );

  // Fixed latency of num_stages cycles
  cordic_rotation_core cordic_rotation_core_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .angle        (angle),
    .angle_valid  (angle_valid),
    .result       (result),
    .result_valid (result_valid)
  );

  // A new load also clears overflow
  sample_fifo sample_fifo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (load),
    .push     (result_valid),
    .data_in  (result),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .overflow (overflow)
  );

endmodule

//--- test/clock_gen.sv
/* Testbench clock and reset source
   Period of 10, reset held low for the first 16 cycles */

module clock_gen (
  output logic clk,
  output logic rst_n
);

  // Free running clock, half period 5
  initial begin : clock_toggle
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Release on a rising edge like any other driven input
  initial begin : reset_pulse
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- test/cordic_nco_tb.sv
/* Testbench for the CORDIC sine and cosine NCO
   Rows from a table applied in a loop and checked against a $sin and $cos model */

module cordic_nco_tb;

  // One table row with a name of up to 12 characters
  typedef struct packed {
    logic [8*12-1:0]        name;
    cordic_nco_pkg::angle_t start;
    cordic_nco_pkg::angle_t step;
    logic [7:0]             count;
    logic                   pop_en;
  } row_t;

  // Model constants
  localparam int  pi_code = int'(cordic_nco_pkg::pi);
  localparam int  two_pi_code = int'(cordic_nco_pkg::two_pi);
  localparam real unit_weight = 2.0 ** cordic_nco_pkg::frac_bits;
  // Start amplitude times the CORDIC gain
  localparam real gain_amplitude = real'(cordic_nco_pkg::cordic_amplitude) * 1.6468;
  localparam int  tolerance = 12;

  logic                    clk;
  logic                    rst_n;
  logic                    load;
  logic                    run;
  cordic_nco_pkg::angle_t  start_angle;
  cordic_nco_pkg::angle_t  step;
  logic                    pop;
  cordic_nco_pkg::sample_t head;
  logic                    empty;
  logic                    overflow;

  row_t                    test_table [$];
  // Samples taken from the FIFO in pop order
  cordic_nco_pkg::sample_t received [$];
  logic [31:0]             lfsr_state;
  int                      value_errors;
  int                      other_errors;
  int                      watchdog_cycles;
  logic                    table_ready;

  clock_gen clock_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cordic_nco_top cordic_nco_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .load        (load),
    .run         (run),
    .start_angle (start_angle),
    .step        (step),
    .pop         (pop),
    .head        (head),
    .empty       (empty),
    .overflow    (overflow)
  );

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // One LFSR step per bit taken
  function automatic int random_bits(input int width);
    int value;
    value = 0;
    for (int b = 0; b < width; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
  endfunction

  // Accumulator wrap rule with one correction at most
  function automatic int wrap_step(input int angle_code, input int step_code);
    int sum;
    sum = angle_code + step_code;
    if (sum > pi_code) begin
      sum = sum - two_pi_code;
    end else if (sum < -pi_code) begin
      sum = sum + two_pi_code;
    end
    return sum;
  endfunction

  function automatic int model_sine(input int angle_code);
    return int'(gain_amplitude * $sin(real'(angle_code) / unit_weight));
  endfunction

  function automatic int model_cosine(input int angle_code);
    return int'(gain_amplitude * $cos(real'(angle_code) / unit_weight));
  endfunction

  function automatic int distance(input int a, input int b);
    return (a > b) ? a - b : b - a;
  endfunction

  ////////////////////////////////////////
  // Table
  ////////////////////////////////////////

  function automatic row_t make_row(input logic [8*12-1:0] name, input int start_code,
                                    input int step_code, input int count, input logic pop_en);
    row_t row;
    row.name   = name;
    row.start  = cordic_nco_pkg::angle_t'(start_code);
    row.step   = cordic_nco_pkg::angle_t'(step_code);
    row.count  = 8'(count);
    row.pop_en = pop_en;
    return row;
  endfunction

  task automatic build_table();
    int rand_start;
    int rand_step;
    int rand_count;
    // Fixed angles over the whole circle with step zero
    test_table.push_back(make_row("zero", 0, 0, 3, 1'b1));
    test_table.push_back(make_row("q1_fixed", 4096, 0, 3, 1'b1));
    test_table.push_back(make_row("q1_edge", 12860, 0, 3, 1'b1));
    test_table.push_back(make_row("q2_edge", 12880, 0, 3, 1'b1));
    test_table.push_back(make_row("q2_fixed", 20000, 0, 3, 1'b1));
    test_table.push_back(make_row("near_pi", 25730, 0, 3, 1'b1));
    test_table.push_back(make_row("q4_fixed", -6000, 0, 3, 1'b1));
    test_table.push_back(make_row("neg_edge", -12868, 0, 3, 1'b1));
    test_table.push_back(make_row("q3_fixed", -18000, 0, 3, 1'b1));
    test_table.push_back(make_row("near_neg_pi", -25730, 0, 3, 1'b1));
    // Start angles beyond pi reach the widest fold before the first wrap
    test_table.push_back(make_row("past_pi", 30000, 0, 3, 1'b1));
    test_table.push_back(make_row("past_neg_pi", -30000, 0, 3, 1'b1));
    // Stepping across plus and minus pi
    test_table.push_back(make_row("pos_wrap", 24000, 700, 20, 1'b1));
    test_table.push_back(make_row("neg_wrap", -24000, -900, 20, 1'b1));
    // Filled first and drained afterwards
    test_table.push_back(make_row("drain", 1000, 1500, 10, 1'b0));
    test_table.push_back(make_row("overflow", -3000, 333, 30, 1'b0));
    // Random rows with starts within plus or minus pi
    for (int k = 0; k < 6; k++) begin
      rand_start = random_bits(16) % two_pi_code - pi_code;
      rand_step  = random_bits(15) - 16384;
      rand_count = 16 + random_bits(4);
      test_table.push_back(make_row({"random_", 8'(48 + k)}, rand_start, rand_step,
                                    rand_count, 1'b1));
    end
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic compare_value(input row_t row, input int index, input string field,
                               input int expected, input int actual);
    if (distance(expected, actual) > tolerance) begin
      value_errors++;
      $display("ERROR %0s sample %0d %0s: expected %0d, actual %0d",
               row.name, index, field, expected, actual);
    end
  endtask

  // Nothing may come out while run stays low
  task automatic check_idle();
    repeat (20) begin
      @(posedge clk);
      if (!empty || overflow) begin
        other_errors++;
        $display("After reset the FIFO is not idle while run is low");
      end
    end
  endtask

  task automatic run_row(input row_t row);
    int expected_count;
    int waited;
    int angle_code;
    received.delete();
    // Load pulse and a pop level for the whole row
    @(posedge clk);
    load        <= 1'b1;
    start_angle <= row.start;
    step        <= row.step;
    pop         <= row.pop_en;
    @(posedge clk);
    load <= 1'b0;
    @(posedge clk);
    if (overflow) begin
      other_errors++;
      $display("%0s: overflow still set after load", row.name);
    end
    run <= 1'b1;
    repeat (row.count) @(posedge clk);
    run <= 1'b0;
    if (row.pop_en) begin
      expected_count = row.count;
    end else begin
      // Only the first fifo_depth samples fit
      expected_count = (row.count > cordic_nco_pkg::fifo_depth) ?
                       cordic_nco_pkg::fifo_depth : row.count;
      repeat (cordic_nco_pkg::num_stages + 4) @(posedge clk);
      if (overflow != (row.count > cordic_nco_pkg::fifo_depth)) begin
        other_errors++;
        $display("%0s: overflow flag is %0b after filling the FIFO", row.name, overflow);
      end
      pop <= 1'b1;
    end
    // Bounded wait for the samples
    waited = 0;
    while (received.size() < expected_count &&
           waited < row.count + cordic_nco_pkg::num_stages + 20) begin
      @(posedge clk);
      waited++;
    end
    pop <= 1'b0;
    repeat (4) @(posedge clk);
    if (received.size() != expected_count) begin
      other_errors++;
      $display("%0s: %0d samples arrived but %0d were expected",
               row.name, received.size(), expected_count);
    end
    if (!empty) begin
      other_errors++;
      $display("%0s: FIFO holds more samples than expected", row.name);
    end
    if (row.pop_en && overflow) begin
      other_errors++;
      $display("%0s: overflow rose although samples were popped", row.name);
    end
    // Walk the model angle alongside the samples
    angle_code = int'(row.start);
    for (int i = 0; i < received.size() && i < expected_count; i++) begin
      compare_value(row, i, "sine", model_sine(angle_code), int'(received[i].sine));
      compare_value(row, i, "cosine", model_cosine(angle_code), int'(received[i].cosine));
      angle_code = wrap_step(angle_code, int'(row.step));
    end
  endtask

  ////////////////////////////////////////
  // Processes
  ////////////////////////////////////////

  // Mid-cycle view of the entry consumed at the next rising edge
  always @(negedge clk) begin : collect_popped
    if (rst_n && pop && !empty) begin
      received.push_back(head);
    end
  end

  initial begin : watchdog
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    $display("Errors found");
    $finish;
  end

  initial begin : main_sequence
    int total_count;
    load         = 1'b0;
    run          = 1'b0;
    start_angle  = '0;
    step         = '0;
    pop          = 1'b0;
    value_errors = 0;
    other_errors = 0;
    table_ready  = 1'b0;
    lfsr_state   = 32'h3ba2;
    build_table();
    // Budget from the sample counts plus a per-row allowance
    total_count = 0;
    for (int r = 0; r < test_table.size(); r++) begin
      total_count += test_table[r].count;
    end
    watchdog_cycles = 16 + 20 + total_count + 40 * test_table.size();
    table_ready = 1'b1;
    @(posedge clk);
    while (!rst_n) begin
      @(posedge clk);
    end
    check_idle();
    for (int r = 0; r < test_table.size(); r++) begin
      run_row(test_table[r]);
    end
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- cordic_nco.f
logic/cordic_nco_pkg.sv
logic/phase_accumulator.sv
logic/cordic_rotation_core.sv
logic/sample_fifo.sv
logic/cordic_nco_top.sv
test/clock_gen.sv
test/cordic_nco_tb.sv

//--- Bender.yml
package:
  name: cordic_nco

sources:
  # Package first, then producer, core, buffer and top level
  - logic/cordic_nco_pkg.sv
  - logic/phase_accumulator.sv
  - logic/cordic_rotation_core.sv
  - logic/sample_fifo.sv
  - logic/cordic_nco_top.sv

  # Simulation only
  - target: test
    files:
      - test/clock_gen.sv
      - test/cordic_nco_tb.sv
